// ==== Makefile ====
TOP   := tb_i3c_cfg
BUILD := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f i3c_cfg.f --top-module $(TOP)

# A $fatal in the testbench makes the binary exit with a nonzero status
sim:
	verilator --binary --timing --assert -f i3c_cfg.f --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

// ==== hw/ccc_handler.sv ====
// Turns accepted CCCs into read-modify-write CSR writes and holds each until granted
`timescale 1ns/10ps
`default_nettype none

module ccc_handler (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   ccc_valid_i,
  input  i3c_cfg_pkg::ccc_cmd_t  ccc_i,

  // Current register content for the merge
  input  i3c_cfg_pkg::csr_bank_t csr_i,

  input  logic                   gnt_i,
  output logic                   req_o,
  output i3c_cfg_pkg::csr_wr_t   wr_o,
  output logic                   busy_o
);

  logic                  known;
  logic                  accept;
  logic                  pending_q;
  i3c_cfg_pkg::ccc_cmd_t cmd_q;

  assign known = (ccc_i.code == i3c_cfg_pkg::CCC_SETDASA) ||
                 (ccc_i.code == i3c_cfg_pkg::CCC_RSTDAA)  ||
                 (ccc_i.code == i3c_cfg_pkg::CCC_SETMWL)  ||
                 (ccc_i.code == i3c_cfg_pkg::CCC_SETMRL);

  assign accept = ccc_valid_i & known & ~pending_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (gnt_i) begin
      pending_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      cmd_q <= ccc_i;
    end
  end

  // Merge against the live word so host writes made while waiting survive
  always_comb begin
    wr_o.addr  = i3c_cfg_pkg::REG_DEVICE_ADDR;
    wr_o.wdata = csr_i[i3c_cfg_pkg::REG_DEVICE_ADDR];
    case (cmd_q.code)
      i3c_cfg_pkg::CCC_SETDASA: begin
        wr_o.wdata[i3c_cfg_pkg::DynAddrLsb +: 7] = cmd_q.data[6:0];
        wr_o.wdata[i3c_cfg_pkg::DynValidBit]     = 1'b1;
      end
      i3c_cfg_pkg::CCC_RSTDAA: begin
        wr_o.wdata[i3c_cfg_pkg::DynValidBit] = 1'b0;
      end
      i3c_cfg_pkg::CCC_SETMWL: begin
        wr_o.addr  = i3c_cfg_pkg::REG_MAX_LEN;
        wr_o.wdata = csr_i[i3c_cfg_pkg::REG_MAX_LEN];
        wr_o.wdata[i3c_cfg_pkg::MwlLsb +: 16] = cmd_q.data;
      end
      i3c_cfg_pkg::CCC_SETMRL: begin
        wr_o.addr  = i3c_cfg_pkg::REG_MAX_LEN;
        wr_o.wdata = csr_i[i3c_cfg_pkg::REG_MAX_LEN];
        wr_o.wdata[i3c_cfg_pkg::MrlLsb +: 16] = cmd_q.data;
      end
      default: ;
    endcase
  end

  assign req_o  = pending_q;
  assign busy_o = pending_q;

  // Protocol engine must wait out the busy level
  no_cmd_while_busy_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    busy_o |-> !ccc_valid_i
  ) else $error("CCC issued while handler busy");

endmodule

`default_nettype wire

// ==== hw/configuration.sv ====
// Decodes the CSR words into the packed settings struct used by the target controller
`timescale 1ns/10ps
`default_nettype none

module configuration (
  input  i3c_cfg_pkg::csr_bank_t csr_i,
  output i3c_cfg_pkg::cfg_t      cfg_o
);

  logic [31:0] hc_ctrl;
  logic [31:0] stby_ctrl;
  logic [31:0] dev_addr;
  logic [31:0] virt_addr;
  logic [31:0] dev_char;
  logic [31:0] max_len;
  logic [31:0] tti_status;

  logic [1:0]  enable_init;
  logic        i3c_active;
  logic        i3c_standby;
  logic [47:0] pid;
  logic [7:0]  bcr;
  logic [7:0]  dcr;
  logic [6:0]  sta_addr;
  logic        sta_valid;
  logic [6:0]  dyn_addr;
  logic        dyn_valid;

  assign hc_ctrl    = csr_i[i3c_cfg_pkg::REG_HC_CONTROL];
  assign stby_ctrl  = csr_i[i3c_cfg_pkg::REG_STBY_CONTROL];
  assign dev_addr   = csr_i[i3c_cfg_pkg::REG_DEVICE_ADDR];
  assign virt_addr  = csr_i[i3c_cfg_pkg::REG_VIRT_DEVICE_ADDR];
  assign dev_char   = csr_i[i3c_cfg_pkg::REG_DEVICE_CHAR];
  assign max_len    = csr_i[i3c_cfg_pkg::REG_MAX_LEN];
  assign tti_status = csr_i[i3c_cfg_pkg::REG_TTI_STATUS];

  // Mode encoding of enable_init
  // 00 disabled, 01 ACM init, 10 SCM running, 11 SCM hot-join
  assign enable_init = stby_ctrl[i3c_cfg_pkg::EnableInitLsb +: 2];
  assign i3c_active  = (enable_init == 2'b01) || (enable_init == 2'b11);
  assign i3c_standby = (enable_init == 2'b10);

  // PID bit 16 is a fixed zero between the two halves
  assign pid = {csr_i[i3c_cfg_pkg::REG_PID_HI][30:0], 1'b0,
                csr_i[i3c_cfg_pkg::REG_PID_LO][15:0]};
  assign dcr = dev_char[i3c_cfg_pkg::DcrLsb +: 8];
  assign bcr = dev_char[i3c_cfg_pkg::BcrLsb +: 8];

  assign sta_addr  = dev_addr[i3c_cfg_pkg::StaAddrLsb +: 7];
  assign sta_valid = dev_addr[i3c_cfg_pkg::StaValidBit];
  assign dyn_addr  = dev_addr[i3c_cfg_pkg::DynAddrLsb +: 7];
  assign dyn_valid = dev_addr[i3c_cfg_pkg::DynValidBit];

  always_comb begin
    cfg_o.phy_en         = hc_ctrl[i3c_cfg_pkg::BusEnableBit];
    // I2C modes are not supported
    cfg_o.i2c_active_en  = 1'b0;
    cfg_o.i2c_standby_en = 1'b0;
    cfg_o.i3c_active_en  = i3c_active;
    cfg_o.i3c_standby_en = i3c_standby;
    cfg_o.phy_mux_select = {i3c_standby, i3c_active | i3c_standby};

    // Bus monitor and timer settings
    cfg_o.t_su_dat        = csr_i[i3c_cfg_pkg::REG_T_SU_DAT][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_hd_dat        = csr_i[i3c_cfg_pkg::REG_T_HD_DAT][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_r             = csr_i[i3c_cfg_pkg::REG_T_R][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_f             = csr_i[i3c_cfg_pkg::REG_T_F][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_bus_free      = csr_i[i3c_cfg_pkg::REG_T_FREE][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_bus_idle      = csr_i[i3c_cfg_pkg::REG_T_IDLE][i3c_cfg_pkg::TimingW-1:0];
    cfg_o.t_bus_available = csr_i[i3c_cfg_pkg::REG_T_AVAL][i3c_cfg_pkg::TimingW-1:0];

    cfg_o.get_mwl = max_len[i3c_cfg_pkg::MwlLsb +: 16];
    cfg_o.get_mrl = max_len[i3c_cfg_pkg::MrlLsb +: 16];

    // Vendor byte zero, handoff not possible, then error and pending interrupt
    cfg_o.get_status_fmt1 = {8'h00, 2'b11, tti_status[i3c_cfg_pkg::ProtoErrBit], 1'b0,
                             tti_status[i3c_cfg_pkg::PendIntrLsb +: 4]};

    cfg_o.pid         = pid;
    cfg_o.bcr         = bcr;
    cfg_o.dcr         = dcr;
    cfg_o.virtual_pid = pid;
    cfg_o.virtual_bcr = bcr;
    cfg_o.virtual_dcr = dcr;

    cfg_o.target_sta_addr               = sta_addr;
    cfg_o.target_sta_addr_valid         = sta_valid;
    cfg_o.target_dyn_addr               = dyn_addr;
    cfg_o.target_dyn_addr_valid         = dyn_valid;
    cfg_o.virtual_target_sta_addr       = virt_addr[i3c_cfg_pkg::StaAddrLsb +: 7];
    cfg_o.virtual_target_sta_addr_valid = virt_addr[i3c_cfg_pkg::StaValidBit];
    cfg_o.virtual_target_dyn_addr       = virt_addr[i3c_cfg_pkg::DynAddrLsb +: 7];
    cfg_o.virtual_target_dyn_addr_valid = virt_addr[i3c_cfg_pkg::DynValidBit];

    // IBIs go out on the dynamic address once one is assigned
    cfg_o.target_ibi_addr       = dyn_valid ? dyn_addr : sta_addr;
    cfg_o.target_ibi_addr_valid = sta_valid | dyn_valid;
    cfg_o.target_hot_join_addr  = i3c_cfg_pkg::HotJoinAddr;

    cfg_o.daa_unique_response = {pid, bcr, dcr};

    cfg_o.ibi_enable    = stby_ctrl[i3c_cfg_pkg::IbiEnBit];
    cfg_o.ibi_retry_num = stby_ctrl[i3c_cfg_pkg::IbiRetryLsb +: 3];
  end

endmodule

`default_nettype wire

// ==== hw/csr_regfile.sv ====
// Sixteen-word CSR store with one arbitrated write port and a registered host read
`timescale 1ns/10ps
`default_nettype none

module csr_regfile (
  input  logic                                clk_i,
  input  logic                                rst_ni,

  // Host read strobe
  input  logic                                host_rd_i,
  input  logic [i3c_cfg_pkg::CsrAddrW-1:0]    host_addr_i,

  // Granted write from the arbiter
  input  logic                                wr_en_i,
  input  i3c_cfg_pkg::csr_wr_t                wr_i,

  output logic [i3c_cfg_pkg::CsrDataW-1:0]    rdata_o,
  output i3c_cfg_pkg::csr_bank_t              csr_o
);

  i3c_cfg_pkg::csr_bank_t                csr_q;
  logic [i3c_cfg_pkg::CsrDataW-1:0]      rdata_q;

  // Register contents
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      csr_q <= '0;
      // Length limits are the only nonzero reset word
      csr_q[i3c_cfg_pkg::REG_MAX_LEN] <= i3c_cfg_pkg::MaxLenResetWord;
    end else if (wr_en_i) begin
      csr_q[wr_i.addr] <= wr_i.wdata;
    end
  end

  // Read data holds until the next read strobe
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (host_rd_i) begin
      rdata_q <= csr_q[host_addr_i];
    end
  end

  assign rdata_o = rdata_q;
  assign csr_o   = csr_q;

  // A granted write must target a defined word
  wr_addr_known_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wr_en_i |-> !$isunknown(wr_i.addr)
  ) else $error("CSR write with unknown address");

endmodule

`default_nettype wire

// ==== hw/csr_write_arbiter.sv ====
// Fixed-priority grant of the single CSR write port, host first and CCC handler second
`timescale 1ns/10ps
`default_nettype none

module csr_write_arbiter (
  input  logic                 host_wr_i,
  input  i3c_cfg_pkg::csr_wr_t host_wr_data_i,

  input  logic                 ccc_req_i,
  input  i3c_cfg_pkg::csr_wr_t ccc_wr_i,
  output logic                 ccc_gnt_o,

  output logic                 wr_en_o,
  output i3c_cfg_pkg::csr_wr_t wr_o
);

  // CCC handler only wins an idle host cycle
  assign ccc_gnt_o = ccc_req_i & ~host_wr_i;

  assign wr_en_o = host_wr_i | ccc_gnt_o;

  always_comb begin
    if (host_wr_i) begin
      wr_o = host_wr_data_i;
    end else begin
      wr_o = ccc_wr_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/i3c_cfg.sv ====
// Top level of the configuration block, joining host CSR access, CCC updates and decode
`timescale 1ns/10ps
`default_nettype none

module i3c_cfg (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // Host CSR port
  input  logic                             host_valid_i,
  input  i3c_cfg_pkg::host_req_t           host_req_i,
  output logic [i3c_cfg_pkg::CsrDataW-1:0] host_rdata_o,

  // CCC port from the protocol engine
  input  logic                             ccc_valid_i,
  input  i3c_cfg_pkg::ccc_cmd_t            ccc_i,
  output logic                             ccc_busy_o,

  output i3c_cfg_pkg::cfg_t                cfg_o
);

  logic                   host_wr;
  logic                   host_rd;
  i3c_cfg_pkg::csr_wr_t   host_wr_data;
  logic                   ccc_req;
  logic                   ccc_gnt;
  i3c_cfg_pkg::csr_wr_t   ccc_wr;
  logic                   wr_en;
  i3c_cfg_pkg::csr_wr_t   wr;
  i3c_cfg_pkg::csr_bank_t csr;

  assign host_wr      = host_valid_i & host_req_i.we;
  assign host_rd      = host_valid_i & ~host_req_i.we;
  assign host_wr_data = '{addr: host_req_i.addr, wdata: host_req_i.wdata};

  csr_regfile i_csr_regfile (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .host_rd_i   (host_rd),
    .host_addr_i (host_req_i.addr),
    .wr_en_i     (wr_en),
    .wr_i        (wr),
    .rdata_o     (host_rdata_o),
    .csr_o       (csr)
  );

  csr_write_arbiter i_csr_write_arbiter (
    .host_wr_i      (host_wr),
    .host_wr_data_i (host_wr_data),
    .ccc_req_i      (ccc_req),
    .ccc_wr_i       (ccc_wr),
    .ccc_gnt_o      (ccc_gnt),
    .wr_en_o        (wr_en),
    .wr_o           (wr)
  );

  ccc_handler i_ccc_handler (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .ccc_valid_i (ccc_valid_i),
    .ccc_i       (ccc_i),
    .csr_i       (csr),
    .gnt_i       (ccc_gnt),
    .req_o       (ccc_req),
    .wr_o        (ccc_wr),
    .busy_o      (ccc_busy_o)
  );

  configuration i_configuration (
    .csr_i (csr),
    .cfg_o (cfg_o)
  );

endmodule

`default_nettype wire

// ==== hw/i3c_cfg_pkg.sv ====
// Register map, field positions, CCC codes and shared types for the I3C target configuration block
`default_nettype none

package i3c_cfg_pkg;

  localparam int unsigned CsrAddrW = 4;
  localparam int unsigned CsrDataW = 32;

  // Register addresses
  localparam logic [CsrAddrW-1:0] REG_HC_CONTROL       = 4'd0;
  localparam logic [CsrAddrW-1:0] REG_STBY_CONTROL     = 4'd1;
  localparam logic [CsrAddrW-1:0] REG_DEVICE_ADDR      = 4'd2;
  localparam logic [CsrAddrW-1:0] REG_PID_LO           = 4'd3;
  localparam logic [CsrAddrW-1:0] REG_PID_HI           = 4'd4;
  localparam logic [CsrAddrW-1:0] REG_DEVICE_CHAR      = 4'd5;
  localparam logic [CsrAddrW-1:0] REG_T_SU_DAT         = 4'd6;
  localparam logic [CsrAddrW-1:0] REG_T_HD_DAT         = 4'd7;
  localparam logic [CsrAddrW-1:0] REG_T_R              = 4'd8;
  localparam logic [CsrAddrW-1:0] REG_T_F              = 4'd9;
  localparam logic [CsrAddrW-1:0] REG_T_FREE           = 4'd10;
  localparam logic [CsrAddrW-1:0] REG_T_IDLE           = 4'd11;
  localparam logic [CsrAddrW-1:0] REG_T_AVAL           = 4'd12;
  localparam logic [CsrAddrW-1:0] REG_MAX_LEN          = 4'd13;
  localparam logic [CsrAddrW-1:0] REG_TTI_STATUS       = 4'd14;
  localparam logic [CsrAddrW-1:0] REG_VIRT_DEVICE_ADDR = 4'd15;

  // Field positions
  localparam int unsigned BusEnableBit  = 0;
  localparam int unsigned EnableInitLsb = 0;
  localparam int unsigned IbiEnBit      = 4;
  localparam int unsigned IbiRetryLsb   = 5;
  localparam int unsigned StaAddrLsb    = 0;
  localparam int unsigned StaValidBit   = 15;
  localparam int unsigned DynAddrLsb    = 16;
  localparam int unsigned DynValidBit   = 31;
  localparam int unsigned DcrLsb        = 0;
  localparam int unsigned BcrLsb        = 8;
  localparam int unsigned TimingW       = 20;
  localparam int unsigned MwlLsb        = 0;
  localparam int unsigned MrlLsb        = 16;
  localparam int unsigned PendIntrLsb   = 0;
  localparam int unsigned ProtoErrBit   = 8;

  // Both length halves come out of reset at 256 bytes
  localparam logic [15:0] MaxLenReset = 16'd256;
  localparam logic [CsrDataW-1:0] MaxLenResetWord = {MaxLenReset, MaxLenReset};

  // Supported CCCs
  localparam logic [7:0] CCC_RSTDAA  = 8'h06;
  localparam logic [7:0] CCC_SETDASA = 8'h87;
  localparam logic [7:0] CCC_SETMWL  = 8'h89;
  localparam logic [7:0] CCC_SETMRL  = 8'h8A;

  localparam logic [6:0] HotJoinAddr = 7'h02;

  typedef logic [15:0][CsrDataW-1:0] csr_bank_t;

  typedef struct packed {
    logic                we;
    logic [CsrAddrW-1:0] addr;
    logic [CsrDataW-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic [CsrAddrW-1:0] addr;
    logic [CsrDataW-1:0] wdata;
  } csr_wr_t;

  typedef struct packed {
    logic [7:0]  code;
    logic [15:0] data;
  } ccc_cmd_t;

  typedef struct packed {
    logic               phy_en;
    logic [1:0]         phy_mux_select;
    logic               i2c_active_en;
    logic               i2c_standby_en;
    logic               i3c_active_en;
    logic               i3c_standby_en;
    logic [TimingW-1:0] t_su_dat;
    logic [TimingW-1:0] t_hd_dat;
    logic [TimingW-1:0] t_r;
    logic [TimingW-1:0] t_f;
    logic [TimingW-1:0] t_bus_free;
    logic [TimingW-1:0] t_bus_idle;
    logic [TimingW-1:0] t_bus_available;
    logic [15:0]        get_mwl;
    logic [15:0]        get_mrl;
    logic [15:0]        get_status_fmt1;
    logic [47:0]        pid;
    logic [7:0]         bcr;
    logic [7:0]         dcr;
    logic [47:0]        virtual_pid;
    logic [7:0]         virtual_bcr;
    logic [7:0]         virtual_dcr;
    logic [6:0]         target_sta_addr;
    logic               target_sta_addr_valid;
    logic [6:0]         target_dyn_addr;
    logic               target_dyn_addr_valid;
    logic [6:0]         virtual_target_sta_addr;
    logic               virtual_target_sta_addr_valid;
    logic [6:0]         virtual_target_dyn_addr;
    logic               virtual_target_dyn_addr_valid;
    logic [6:0]         target_ibi_addr;
    logic               target_ibi_addr_valid;
    logic [6:0]         target_hot_join_addr;
    logic [63:0]        daa_unique_response;
    logic               ibi_enable;
    logic [2:0]         ibi_retry_num;
  } cfg_t;

endpackage

`default_nettype wire

// ==== i3c_cfg.f ====
hw/i3c_cfg_pkg.sv
hw/csr_regfile.sv
hw/csr_write_arbiter.sv
hw/ccc_handler.sv
hw/configuration.sv
hw/i3c_cfg.sv
tb/tb_i3c_cfg.sv

// ==== tb/tb_i3c_cfg.sv ====
// Testbench for the I3C configuration block, checks cfg_o against a register model every cycle
`timescale 1ns/10ps
`default_nettype none

module tb_i3c_cfg;

  localparam int NumRandWrites = 192;
  localparam int NumModeWrites = 8;
  localparam int NumReads      = 16;
  localparam int NumCcc        = 13;
  localparam int NumContention = 8;
  localparam int NumAccesses   = NumRandWrites + NumModeWrites + NumReads + NumCcc + NumContention;
  localparam int WatchdogNs    = NumAccesses * 20 + 2000;
  localparam int BusyTimeout   = 50;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   host_valid_i;
  i3c_cfg_pkg::host_req_t host_req_i;
  logic [31:0]            host_rdata_o;
  logic                   ccc_valid_i;
  i3c_cfg_pkg::ccc_cmd_t  ccc_i;
  logic                   ccc_busy_o;
  i3c_cfg_pkg::cfg_t      cfg_o;

  // Register model and the expected handler and read state
  i3c_cfg_pkg::csr_bank_t model;
  i3c_cfg_pkg::ccc_cmd_t  exp_cmd;
  logic                   exp_busy;
  logic [31:0]            exp_rdata;
  logic                   checking;

  i3c_cfg i_i3c_cfg (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .host_valid_i (host_valid_i),
    .host_req_i   (host_req_i),
    .host_rdata_o (host_rdata_o),
    .ccc_valid_i  (ccc_valid_i),
    .ccc_i        (ccc_i),
    .ccc_busy_o   (ccc_busy_o),
    .cfg_o        (cfg_o)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "Stopping at first error");
  endtask

  function automatic logic ccc_known(input logic [7:0] code);
    return (code == 8'h87) || (code == 8'h06) || (code == 8'h89) || (code == 8'h8A);
  endfunction

  // Field updates of the four CCCs on the model words
  function automatic i3c_cfg_pkg::csr_bank_t apply_ccc(input i3c_cfg_pkg::csr_bank_t m,
                                                       input i3c_cfg_pkg::ccc_cmd_t cmd);
    case (cmd.code)
      8'h87: begin
        m[2][22:16] = cmd.data[6:0];
        m[2][31]    = 1'b1;
      end
      8'h06: m[2][31] = 1'b0;
      8'h89: m[13][15:0] = cmd.data;
      8'h8A: m[13][31:16] = cmd.data;
      default: ;
    endcase
    return m;
  endfunction

  function automatic i3c_cfg_pkg::cfg_t model_cfg(input i3c_cfg_pkg::csr_bank_t m);
    i3c_cfg_pkg::cfg_t c;
    logic [31:0]       da;
    logic [31:0]       va;
    logic              act;
    logic              stby;
    da   = m[2];
    va   = m[15];
    act  = m[1][0];
    stby = (m[1][1:0] == 2'b10);
    c = '0;
    c.phy_en           = m[0][0];
    c.i3c_active_en    = act;
    c.i3c_standby_en   = stby;
    c.phy_mux_select   = {stby, act | stby};
    c.t_su_dat         = m[6][19:0];
    c.t_hd_dat         = m[7][19:0];
    c.t_r              = m[8][19:0];
    c.t_f              = m[9][19:0];
    c.t_bus_free       = m[10][19:0];
    c.t_bus_idle       = m[11][19:0];
    c.t_bus_available  = m[12][19:0];
    c.get_mwl          = m[13][15:0];
    c.get_mrl          = m[13][31:16];
    c.get_status_fmt1  = {8'h00, 2'b11, m[14][8], 1'b0, m[14][3:0]};
    c.pid              = {m[4][30:0], 1'b0, m[3][15:0]};
    c.dcr              = m[5][7:0];
    c.bcr              = m[5][15:8];
    c.virtual_pid      = c.pid;
    c.virtual_bcr      = c.bcr;
    c.virtual_dcr      = c.dcr;
    c.target_sta_addr               = da[6:0];
    c.target_sta_addr_valid         = da[15];
    c.target_dyn_addr               = da[22:16];
    c.target_dyn_addr_valid         = da[31];
    c.virtual_target_sta_addr       = va[6:0];
    c.virtual_target_sta_addr_valid = va[15];
    c.virtual_target_dyn_addr       = va[22:16];
    c.virtual_target_dyn_addr_valid = va[31];
    c.target_ibi_addr       = da[31] ? da[22:16] : da[6:0];
    c.target_ibi_addr_valid = da[15] | da[31];
    c.target_hot_join_addr  = 7'h02;
    c.daa_unique_response   = {c.pid, c.bcr, c.dcr};
    c.ibi_enable            = m[1][4];
    c.ibi_retry_num         = m[1][7:5];
    return c;
  endfunction

  // Compares pre-edge outputs, then moves the model across the edge
  always @(posedge clk_i) begin : compare_proc
    i3c_cfg_pkg::cfg_t exp_cfg;
    logic              host_wr;
    logic              busy_before;
    if (checking) begin
      exp_cfg = model_cfg(model);
      assert (cfg_o == exp_cfg) else begin
        $display("[FAIL] %0t cfg_o expected %h got %h", $time, exp_cfg, cfg_o);
        abort_run();
      end
      assert (ccc_busy_o == exp_busy) else begin
        $display("[FAIL] %0t ccc_busy_o expected %b got %b", $time, exp_busy, ccc_busy_o);
        abort_run();
      end
      assert (host_rdata_o == exp_rdata) else begin
        $display("[FAIL] %0t host_rdata_o expected %h got %h", $time, exp_rdata, host_rdata_o);
        abort_run();
      end
      host_wr     = host_valid_i & host_req_i.we;
      busy_before = exp_busy;
      if (host_valid_i && !host_req_i.we) begin
        exp_rdata = model[host_req_i.addr];
      end
      if (host_wr) begin
        model[host_req_i.addr] = host_req_i.wdata;
      end else if (busy_before) begin
        model    = apply_ccc(model, exp_cmd);
        exp_busy = 1'b0;
      end
      if (ccc_valid_i && ccc_known(ccc_i.code) && !busy_before) begin
        exp_cmd  = ccc_i;
        exp_busy = 1'b1;
      end
    end
  end

  task automatic host_write(input logic [3:0] addr, input logic [31:0] data);
    host_req_i   = '{we: 1'b1, addr: addr, wdata: data};
    host_valid_i = 1'b1;
    @(negedge clk_i);
    host_valid_i = 1'b0;
  endtask

  task automatic host_read(input logic [3:0] addr);
    host_req_i   = '{we: 1'b0, addr: addr, wdata: 32'h0};
    host_valid_i = 1'b1;
    @(negedge clk_i);
    host_valid_i = 1'b0;
  endtask

  task automatic wait_ccc_idle();
    int n;
    n = 0;
    while (ccc_busy_o && n < BusyTimeout) begin
      @(negedge clk_i);
      n++;
    end
    assert (!ccc_busy_o) else begin
      $display("CCC handler stayed busy for %0d cycles without being granted", BusyTimeout);
      abort_run();
    end
  endtask

  task automatic ccc_send(input logic [7:0] code, input logic [15:0] data);
    ccc_i       = '{code: code, data: data};
    ccc_valid_i = 1'b1;
    @(negedge clk_i);
    ccc_valid_i = 1'b0;
    if (ccc_known(code)) begin
      wait_ccc_idle();
    end else begin
      assert (!ccc_busy_o) else begin
        $display("[FAIL] %0t ccc_busy_o expected 0 got %b for code %h", $time, ccc_busy_o, code);
        abort_run();
      end
    end
  endtask

  // Command issued together with four back-to-back host writes to the same word
  task automatic ccc_under_host_writes(input logic [7:0] code, input logic [3:0] addr);
    ccc_i       = '{code: code, data: 16'($urandom())};
    ccc_valid_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      host_req_i   = '{we: 1'b1, addr: addr, wdata: $urandom()};
      host_valid_i = 1'b1;
      @(negedge clk_i);
      ccc_valid_i = 1'b0;
    end
    host_valid_i = 1'b0;
    assert (ccc_busy_o) else begin
      $display("[FAIL] %0t ccc_busy_o expected 1 got %b", $time, ccc_busy_o);
      abort_run();
    end
    wait_ccc_idle();
  endtask

  initial begin : watchdog
    #(WatchdogNs);
    $display("Watchdog expired after %0d ns, the run hung", WatchdogNs);
    abort_run();
  end

  initial begin : stimulus
    logic [31:0] data;
    logic [7:0]  code;
    void'($urandom(69913));
    rst_ni       = 1'b0;
    host_valid_i = 1'b0;
    host_req_i   = '0;
    ccc_valid_i  = 1'b0;
    ccc_i        = '0;
    checking     = 1'b0;
    exp_busy     = 1'b0;
    exp_rdata    = 32'h0;
    exp_cmd      = '0;
    model        = '0;
    model[13]    = {16'd256, 16'd256};
    repeat (5) @(negedge clk_i);
    rst_ni   = 1'b1;
    checking = 1'b1;

    assert (cfg_o.get_mwl == 16'd256 && cfg_o.get_mrl == 16'd256) else begin
      $display("[FAIL] %0t get_mwl/get_mrl expected 0100/0100 got %h/%h",
               $time, cfg_o.get_mwl, cfg_o.get_mrl);
      abort_run();
    end
    assert ({cfg_o.i2c_active_en, cfg_o.i2c_standby_en, cfg_o.i3c_active_en,
             cfg_o.i3c_standby_en, ccc_busy_o} == 5'b0) else begin
      $display("[FAIL] %0t mode enables and ccc_busy_o expected 0 got %b%b%b%b %b", $time,
               cfg_o.i2c_active_en, cfg_o.i2c_standby_en, cfg_o.i3c_active_en,
               cfg_o.i3c_standby_en, ccc_busy_o);
      abort_run();
    end

    for (int i = 0; i < NumRandWrites; i++) begin
      host_write(4'(i), $urandom());
    end
    // Every enable_init value and every address valid combination
    for (int i = 0; i < 4; i++) begin
      host_write(4'd1, ($urandom() & 32'hFFFF_FFFC) | 32'(i));
      data     = $urandom();
      data[15] = i[0];
      data[31] = i[1];
      host_write(4'd2, data);
    end
    for (int i = 0; i < NumReads; i++) begin
      host_read(4'(i));
    end

    ccc_send(8'h87, 16'($urandom()));
    ccc_send(8'h89, 16'($urandom()));
    ccc_send(8'h8A, 16'($urandom()));
    ccc_send(8'h06, 16'h0);
    ccc_send(8'h87, 16'($urandom()));
    for (int i = 0; i < 8; i++) begin
      code = 8'($urandom());
      if (ccc_known(code)) begin
        code = 8'h01;
      end
      ccc_send(code, 16'($urandom()));
    end

    ccc_under_host_writes(8'h87, 4'd2);
    ccc_under_host_writes(8'h8A, 4'd13);
    host_read(4'd2);
    repeat (3) @(negedge clk_i);
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire
